// ==== hdl/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and address widths
`define DATA_W 8
`define ADDR_W 8
`define PC_W 10

// Instruction word layout
`define INSTR_W 16
`define REG_AW 3
`define OPC_W 5

// Register file depth
`define REG_N 8

// A JMP to its own address ends a program
`define HALT_OPC 5'h07

`endif

// ==== hdl/isa_pkg.sv ====
`include "core_consts.svh"

package isa_pkg;

	// Opcodes not listed here behave as NOP
	typedef enum logic [`OPC_W-1:0] {
		OP_NOP   = 5'h00,
		OP_ADD   = 5'h01,
		OP_SUB   = 5'h02,
		OP_SHL   = 5'h06,
		OP_JMP   = 5'h07,
		OP_LOAD  = 5'h08,
		OP_STORE = 5'h09,
		OP_ANDB  = 5'h0a,
		OP_ORB   = 5'h0b,
		OP_CMP   = 5'h0d,
		OP_JMPGT = 5'h0e,
		OP_JMPLT = 5'h0f,
		OP_JMPEQ = 5'h10
	} opcode_e;

	// Register to register form
	typedef struct packed {
		opcode_e opcode;
		logic [`REG_AW-1:0] rd;
		logic pad_hi;
		logic [`REG_AW-1:0] rs2;
		logic pad_lo;
		logic [`REG_AW-1:0] rs1;
	} reg_view_t;

	typedef struct packed {
		opcode_e opcode;
		logic [`REG_AW-1:0] rd;
		logic [`ADDR_W-1:0] addr;
	} load_view_t;

	// Store data register sits in the rs1 slot
	typedef struct packed {
		opcode_e opcode;
		logic [`ADDR_W-1:0] addr;
		logic [`REG_AW-1:0] rs1;
	} store_view_t;

	typedef struct packed {
		opcode_e opcode;
		logic pad;
		logic [`PC_W-1:0] target;
	} branch_view_t;

	typedef union packed {
		reg_view_t reg_v;
		load_view_t ld_v;
		store_view_t st_v;
		branch_view_t br_v;
	} instr_u;

endpackage

// ==== hdl/pipe_pkg.sv ====
`include "core_consts.svh"

package pipe_pkg;

	typedef struct packed {
		logic alu_add;
		logic sub;
		logic and_b;
		logic or_b;
		logic shl;
		logic cmp;
		logic load;
		logic store;
		logic reg_write;
		logic jmp;
		logic jmp_gt;
		logic jmp_lt;
		logic jmp_eq;
	} ctrl_t;

	// Decode to execute payload
	typedef struct packed {
		ctrl_t ctrl;
		logic [`DATA_W-1:0] op1;
		logic [`DATA_W-1:0] op2;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rd;
		logic [`ADDR_W-1:0] mem_addr;
		logic [`PC_W-1:0] target;
	} dex_t;

	// What the store-result stage needs from execute
	typedef struct packed {
		logic reg_write;
		logic store;
		logic load;
		logic cmp;
		logic [`REG_AW-1:0] rd;
		logic [`ADDR_W-1:0] mem_addr;
	} ex_ctrl_t;

	typedef struct packed {
		logic gt;
		logic lt;
		logic eq;
	} flags_t;

	typedef struct packed {
		logic en;
		logic [`REG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
	} rf_write_t;

	typedef struct packed {
		logic en;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} mem_write_t;

	// Take the store-result write data when it targets this operand
	function automatic logic [`DATA_W-1:0] bypass(input rf_write_t wr,
			input logic [`REG_AW-1:0] addr, input logic [`DATA_W-1:0] data);
		return (wr.en && (wr.addr == addr)) ? wr.data : data;
	endfunction

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_stage (
	input logic clk,
	input logic reset,
	input logic branch_now,
	input logic [`PC_W-1:0] branch_target,
	output logic [`PC_W-1:0] pc,
	input isa_pkg::instr_u instr,
	output isa_pkg::instr_u f_instr,
	output logic f_valid
);

	// PC and fetch valid bit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			f_valid <= 1'b0;
		end
		else
		begin
			if (branch_now)
				pc <= branch_target;
			else
				pc <= pc + 1'b1;
			// Word fetched under a taken branch is dropped
			f_valid <= !branch_now;
		end
	end

	// Instruction register
	always_ff @(posedge clk)
	begin
		f_instr <= instr;
	end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	input isa_pkg::instr_u instr,
	output pipe_pkg::ctrl_t ctrl
);

	always_comb
	begin
		ctrl = '0;
		case (instr.reg_v.opcode)
			isa_pkg::OP_ADD:
			begin
				ctrl.alu_add = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_SUB:
			begin
				ctrl.alu_add = 1'b1;
				ctrl.sub = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_ANDB:
			begin
				ctrl.and_b = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_ORB:
			begin
				ctrl.or_b = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_SHL:
			begin
				ctrl.shl = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_LOAD:
			begin
				ctrl.load = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::OP_STORE:
				ctrl.store = 1'b1;
			// Compare is a subtract that only sets flags
			isa_pkg::OP_CMP:
			begin
				ctrl.alu_add = 1'b1;
				ctrl.sub = 1'b1;
				ctrl.cmp = 1'b1;
			end
			isa_pkg::OP_JMP:
				ctrl.jmp = 1'b1;
			isa_pkg::OP_JMPGT:
				ctrl.jmp_gt = 1'b1;
			isa_pkg::OP_JMPLT:
				ctrl.jmp_lt = 1'b1;
			isa_pkg::OP_JMPEQ:
				ctrl.jmp_eq = 1'b1;
			default:
				ctrl = '0;
		endcase
	end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_stage (
	input logic clk,
	input logic reset,
	input isa_pkg::instr_u f_instr,
	input logic f_valid,
	input logic squash,
	input logic [`DATA_W-1:0] rf_rd_data_a,
	input logic [`DATA_W-1:0] rf_rd_data_b,
	input pipe_pkg::rf_write_t rf_wr,
	output logic [`REG_AW-1:0] rf_rd_addr_a,
	output logic [`REG_AW-1:0] rf_rd_addr_b,
	output pipe_pkg::dex_t dex,
	output logic d_valid
);

	pipe_pkg::ctrl_t ctrl;
	logic [`DATA_W-1:0] op1;
	logic [`DATA_W-1:0] op2;
	logic [`ADDR_W-1:0] mem_addr;

	instr_decoder u_dec (
		.instr (f_instr),
		.ctrl  (ctrl)
	);

	//********************************************************************
	// Operand read and bypass
	//********************************************************************

	assign rf_rd_addr_a = f_instr.reg_v.rs1;
	assign rf_rd_addr_b = f_instr.reg_v.rs2;

	// Register file write lands at this edge, so take it early
	assign op1 = pipe_pkg::bypass(rf_wr, f_instr.reg_v.rs1, rf_rd_data_a);
	assign op2 = pipe_pkg::bypass(rf_wr, f_instr.reg_v.rs2, rf_rd_data_b);

	// Loads and stores keep their address in different fields
	assign mem_addr = ctrl.store ? f_instr.st_v.addr : f_instr.ld_v.addr;

	//********************************************************************
	// Decode to execute registers
	//********************************************************************

	always_ff @(posedge clk)
	begin
		dex.ctrl <= ctrl;
		dex.op1 <= op1;
		dex.op2 <= op2;
		dex.rs1 <= f_instr.reg_v.rs1;
		dex.rs2 <= f_instr.reg_v.rs2;
		dex.rd <= f_instr.reg_v.rd;
		dex.mem_addr <= mem_addr;
		dex.target <= f_instr.br_v.target;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			d_valid <= 1'b0;
		else
			d_valid <= f_valid && !squash;
	end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_stage (
	input logic clk,
	input logic reset,
	input pipe_pkg::dex_t dex,
	input logic d_valid,
	input logic squash,
	input pipe_pkg::rf_write_t rf_wr,
	input pipe_pkg::flags_t committed,
	output logic branch_taken,
	output logic [`PC_W-1:0] branch_target,
	output logic [`DATA_W-1:0] ex_result,
	output pipe_pkg::flags_t ex_flags,
	output pipe_pkg::ex_ctrl_t ex_ctrl,
	output logic e_valid
);

	logic [`DATA_W-1:0] op1;
	logic [`DATA_W-1:0] op2;
	logic [`DATA_W-1:0] op2_in;
	logic [`DATA_W:0] sum;
	logic zero;
	logic [`DATA_W-1:0] alu_out;
	pipe_pkg::flags_t flags_now;
	pipe_pkg::flags_t fwd_flags;
	logic sr_cmp;

	//********************************************************************
	// Operand bypass from store-result
	//********************************************************************

	assign op1 = pipe_pkg::bypass(rf_wr, dex.rs1, dex.op1);
	assign op2 = pipe_pkg::bypass(rf_wr, dex.rs2, dex.op2);

	//********************************************************************
	// Adder, shifter and bitwise unit
	//********************************************************************

	// Store passes operand 1 through the adder unchanged
	always_comb
	begin
		if (dex.ctrl.store)
			op2_in = '0;
		else if (dex.ctrl.sub)
			op2_in = ~op2;
		else
			op2_in = op2;
	end

	assign sum = {1'b0, op1} + {1'b0, op2_in} + {{`DATA_W{1'b0}}, dex.ctrl.sub};
	assign zero = (sum[`DATA_W-1:0] == '0);

	always_comb
	begin
		if (dex.ctrl.alu_add || dex.ctrl.store)
			alu_out = sum[`DATA_W-1:0];
		else if (dex.ctrl.and_b)
			alu_out = op1 & op2;
		else if (dex.ctrl.or_b)
			alu_out = op1 | op2;
		else if (dex.ctrl.shl)
			alu_out = {op1[`DATA_W-2:0], 1'b0};
		else
			alu_out = '0;
	end

	// Carry set means no borrow, so op1 >= op2
	assign flags_now.gt = sum[`DATA_W] && !zero;
	assign flags_now.lt = !sum[`DATA_W] && !zero;
	assign flags_now.eq = zero;

	//********************************************************************
	// Branch condition
	//********************************************************************

	// A compare one ahead has not committed yet
	assign sr_cmp = e_valid && ex_ctrl.cmp;
	assign fwd_flags = sr_cmp ? ex_flags : committed;

	assign branch_taken = d_valid && (dex.ctrl.jmp ||
		(dex.ctrl.jmp_gt && fwd_flags.gt) ||
		(dex.ctrl.jmp_lt && fwd_flags.lt) ||
		(dex.ctrl.jmp_eq && fwd_flags.eq));

	//********************************************************************
	// Execute to store-result registers
	//********************************************************************

	always_ff @(posedge clk)
	begin
		ex_result <= alu_out;
		ex_flags <= flags_now;
		branch_target <= dex.target;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ex_ctrl <= '0;
			e_valid <= 1'b0;
		end
		else
		begin
			ex_ctrl.reg_write <= dex.ctrl.reg_write;
			ex_ctrl.store <= dex.ctrl.store;
			ex_ctrl.load <= dex.ctrl.load;
			ex_ctrl.cmp <= dex.ctrl.cmp;
			ex_ctrl.rd <= dex.rd;
			ex_ctrl.mem_addr <= dex.mem_addr;
			e_valid <= d_valid && !squash;
		end
	end

endmodule

// ==== hdl/commit_control.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module commit_control (
	input logic clk,
	input logic reset,
	input logic branch_taken,
	input logic [`DATA_W-1:0] ex_result,
	input pipe_pkg::flags_t ex_flags,
	input pipe_pkg::ex_ctrl_t ex_ctrl,
	input logic e_valid,
	input logic [`DATA_W-1:0] dmem_rd_data,
	output pipe_pkg::rf_write_t rf_wr,
	output pipe_pkg::mem_write_t dmem_wr,
	output logic [`ADDR_W-1:0] dmem_rd_addr,
	output pipe_pkg::flags_t committed,
	output logic branch_now,
	output logic squash
);

	// Store-result writes, memory read is combinational
	assign dmem_rd_addr = ex_ctrl.mem_addr;

	assign rf_wr.en = e_valid && ex_ctrl.reg_write;
	assign rf_wr.addr = ex_ctrl.rd;
	assign rf_wr.data = ex_ctrl.load ? dmem_rd_data : ex_result;

	assign dmem_wr.en = e_valid && ex_ctrl.store;
	assign dmem_wr.addr = ex_ctrl.mem_addr;
	assign dmem_wr.data = ex_result;

	// Flags commit only from a surviving compare
	always_ff @(posedge clk)
	begin
		if (reset)
			committed <= '0;
		else if (e_valid && ex_ctrl.cmp)
			committed <= ex_flags;
	end

	// A branch right behind a taken one is itself squashed
	always_ff @(posedge clk)
	begin
		if (reset)
			branch_now <= 1'b0;
		else
			branch_now <= branch_taken && !branch_now;
	end

	assign squash = branch_now;

endmodule

// ==== hdl/processor_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module processor_core (
	input logic clk,
	input logic reset,
	output logic [`PC_W-1:0] pc,
	input isa_pkg::instr_u instr,
	output logic [`REG_AW-1:0] rf_rd_addr_a,
	output logic [`REG_AW-1:0] rf_rd_addr_b,
	input logic [`DATA_W-1:0] rf_rd_data_a,
	input logic [`DATA_W-1:0] rf_rd_data_b,
	output pipe_pkg::rf_write_t rf_wr,
	output logic [`ADDR_W-1:0] dmem_rd_addr,
	input logic [`DATA_W-1:0] dmem_rd_data,
	output pipe_pkg::mem_write_t dmem_wr
);

	isa_pkg::instr_u f_instr;
	logic f_valid;
	pipe_pkg::dex_t dex;
	logic d_valid;
	logic branch_taken;
	logic [`PC_W-1:0] branch_target;
	logic [`DATA_W-1:0] ex_result;
	pipe_pkg::flags_t ex_flags;
	pipe_pkg::ex_ctrl_t ex_ctrl;
	logic e_valid;
	pipe_pkg::flags_t committed;
	logic branch_now;
	logic squash;

	fetch_stage u_fetch (
		.clk           (clk),
		.reset         (reset),
		.branch_now    (branch_now),
		.branch_target (branch_target),
		.pc            (pc),
		.instr         (instr),
		.f_instr       (f_instr),
		.f_valid       (f_valid)
	);

	decode_stage u_decode (
		.clk          (clk),
		.reset        (reset),
		.f_instr      (f_instr),
		.f_valid      (f_valid),
		.squash       (squash),
		.rf_rd_data_a (rf_rd_data_a),
		.rf_rd_data_b (rf_rd_data_b),
		.rf_wr        (rf_wr),
		.rf_rd_addr_a (rf_rd_addr_a),
		.rf_rd_addr_b (rf_rd_addr_b),
		.dex          (dex),
		.d_valid      (d_valid)
	);

	execute_stage u_execute (
		.clk           (clk),
		.reset         (reset),
		.dex           (dex),
		.d_valid       (d_valid),
		.squash        (squash),
		.rf_wr         (rf_wr),
		.committed     (committed),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.ex_result     (ex_result),
		.ex_flags      (ex_flags),
		.ex_ctrl       (ex_ctrl),
		.e_valid       (e_valid)
	);

	commit_control u_commit (
		.clk          (clk),
		.reset        (reset),
		.branch_taken (branch_taken),
		.ex_result    (ex_result),
		.ex_flags     (ex_flags),
		.ex_ctrl      (ex_ctrl),
		.e_valid      (e_valid),
		.dmem_rd_data (dmem_rd_data),
		.rf_wr        (rf_wr),
		.dmem_wr      (dmem_wr),
		.dmem_rd_addr (dmem_rd_addr),
		.committed    (committed),
		.branch_now   (branch_now),
		.squash       (squash)
	);

endmodule

// ==== verif/tb_model_pkg.sv ====
`include "core_consts.svh"

package tb_model_pkg;

	typedef logic [`INSTR_W-1:0] word_q_t[$];
	typedef logic [`REG_AW+`DATA_W-1:0] rfw_q_t[$];
	typedef logic [`ADDR_W+`DATA_W-1:0] memw_q_t[$];
	typedef logic [`PC_W-1:0] pc_q_t[$];

	// Power-up contents of the register file and data memory
	function automatic logic [`DATA_W-1:0] rf_init(input int idx);
		return `DATA_W'(idx * 29 + 3);
	endfunction

	function automatic logic [`DATA_W-1:0] dmem_init(input int addr);
		return `DATA_W'((addr * 7) ^ 8'ha5);
	endfunction

	// Instruction encoders
	function automatic logic [`INSTR_W-1:0] enc_reg(input isa_pkg::opcode_e op,
			input logic [2:0] rd, input logic [2:0] rs2, input logic [2:0] rs1);
		return {op, rd, 1'b0, rs2, 1'b0, rs1};
	endfunction

	function automatic logic [`INSTR_W-1:0] enc_load(input logic [2:0] rd,
			input logic [7:0] addr);
		return {isa_pkg::OP_LOAD, rd, addr};
	endfunction

	function automatic logic [`INSTR_W-1:0] enc_store(input logic [7:0] addr,
			input logic [2:0] rs1);
		return {isa_pkg::OP_STORE, addr, rs1};
	endfunction

	function automatic logic [`INSTR_W-1:0] enc_br(input isa_pkg::opcode_e op,
			input int target);
		return {op, 1'b0, `PC_W'(target)};
	endfunction

	//**********************************************************************
	// ISA-level execution of one instruction at a time
	//**********************************************************************

	function automatic void run_model(input word_q_t prog, output rfw_q_t rq,
			output memw_q_t mq, output pc_q_t bq, output logic [`PC_W-1:0] halt);
		logic [`DATA_W-1:0] r [`REG_N];
		logic [`DATA_W-1:0] m [256];
		logic gt;
		logic lt;
		logic eq;
		logic take;
		logic wr;
		logic [`INSTR_W-1:0] w;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] res;
		int pc;
		int tgt;
		rq = {};
		mq = {};
		bq = {};
		halt = '0;
		for (int i = 0; i < `REG_N; i++)
			r[i] = rf_init(i);
		for (int i = 0; i < 256; i++)
			m[i] = dmem_init(i);
		gt = 1'b0;
		lt = 1'b0;
		eq = 1'b0;
		pc = 0;
		for (int steps = 0; steps < 4096; steps++)
		begin
			w = (pc < prog.size()) ? prog[pc] : '0;
			a = r[w[2:0]];
			b = r[w[6:4]];
			res = '0;
			take = 1'b0;
			wr = 1'b0;
			case (w[15:11])
				5'h01:
				begin
					res = a + b;
					wr = 1'b1;
				end
				5'h02:
				begin
					res = a - b;
					wr = 1'b1;
				end
				5'h06:
				begin
					res = {a[6:0], 1'b0};
					wr = 1'b1;
				end
				5'h0a:
				begin
					res = a & b;
					wr = 1'b1;
				end
				5'h0b:
				begin
					res = a | b;
					wr = 1'b1;
				end
				5'h08:
				begin
					res = m[w[7:0]];
					wr = 1'b1;
				end
				5'h09:
				begin
					m[w[10:3]] = a;
					mq.push_back({w[10:3], a});
				end
				5'h0d:
				begin
					gt = a > b;
					lt = a < b;
					eq = a == b;
				end
				5'h07: take = 1'b1;
				5'h0e: take = gt;
				5'h0f: take = lt;
				5'h10: take = eq;
				default: take = 1'b0;
			endcase
			if (wr)
			begin
				r[w[10:8]] = res;
				rq.push_back({w[10:8], res});
			end
			tgt = int'(w[`PC_W-1:0]);
			// Self-jump ends the program
			if (take && tgt == pc)
			begin
				halt = `PC_W'(pc);
				return;
			end
			if (take)
			begin
				// A target four ahead looks like a plain increment on pc
				if (tgt != pc + 4)
					bq.push_back(`PC_W'(tgt));
				pc = tgt;
			end
			else
				pc = pc + 1;
		end
	endfunction

	//**********************************************************************
	// Program builders
	//**********************************************************************

	function automatic void build_directed(output word_q_t p);
		p = {};
		p.push_back(enc_reg(isa_pkg::OP_ADD, 1, 2, 1));
		p.push_back(enc_reg(isa_pkg::OP_SUB, 3, 3, 1));
		p.push_back(enc_reg(isa_pkg::OP_SHL, 4, 0, 3));
		p.push_back(enc_reg(isa_pkg::OP_ANDB, 5, 1, 4));
		p.push_back(enc_reg(isa_pkg::OP_ORB, 6, 3, 5));
		// Store then load back the same byte
		p.push_back(enc_store(8'h40, 6));
		p.push_back(enc_load(7, 8'h40));
		p.push_back(enc_reg(isa_pkg::OP_ADD, 0, 7, 7));
		p.push_back(enc_reg(isa_pkg::OP_CMP, 0, 1, 1));
		p.push_back(enc_br(isa_pkg::OP_JMPEQ, 13));
		p.push_back(enc_reg(isa_pkg::OP_ADD, 2, 2, 2));
		p.push_back(enc_store(8'h41, 2));
		p.push_back(enc_load(3, 8'h10));
		// Addr 13 flags used directly and then from the committed copy
		p.push_back(enc_reg(isa_pkg::OP_CMP, 0, 6, 6));
		p.push_back(enc_br(isa_pkg::OP_JMPGT, 21));
		p.push_back(enc_br(isa_pkg::OP_JMPLT, 21));
		p.push_back(enc_br(isa_pkg::OP_JMPEQ, 21));
		p.push_back(enc_reg(isa_pkg::OP_ORB, 1, 2, 1));
		p.push_back(enc_reg(isa_pkg::OP_ANDB, 2, 3, 2));
		p.push_back(enc_reg(isa_pkg::OP_SUB, 4, 4, 0));
		p.push_back(enc_store(8'h42, 1));
		// Addr 21
		p.push_back(enc_br(isa_pkg::OP_JMP, 25));
		// Jump in the first squashed slot
		p.push_back(enc_br(isa_pkg::OP_JMP, 10));
		p.push_back(enc_reg(isa_pkg::OP_SHL, 6, 0, 6));
		p.push_back(enc_store(8'h43, 5));
		// Addr 25
		p.push_back(enc_reg(isa_pkg::OP_CMP, 0, 5, 0));
		p.push_back(enc_reg(isa_pkg::OP_ADD, 2, 5, 0));
		p.push_back(enc_br(isa_pkg::OP_JMPGT, 31));
		p.push_back(enc_reg(isa_pkg::OP_SHL, 3, 0, 2));
		p.push_back(enc_br(isa_pkg::OP_JMPLT, 33));
		p.push_back(enc_reg(isa_pkg::OP_ADD, 4, 3, 2));
		p.push_back(enc_store(8'h80, 2));
		p.push_back(enc_reg(isa_pkg::OP_CMP, 0, 2, 2));
		// Addr 33
		p.push_back(enc_reg(isa_pkg::OP_SUB, 1, 0, 2));
		p.push_back(enc_reg(isa_pkg::OP_CMP, 0, 4, 1));
		p.push_back(enc_br(isa_pkg::OP_JMPLT, 38));
		p.push_back(enc_reg(isa_pkg::OP_ORB, 7, 4, 1));
		p.push_back(enc_store(8'h81, 7));
		p.push_back(enc_load(5, 8'h80));
		p.push_back(enc_store(8'h82, 5));
		p.push_back(enc_load(6, 8'h82));
		p.push_back(enc_reg(isa_pkg::OP_ADD, 0, 5, 6));
		p.push_back(enc_store(8'h83, 0));
		p.push_back(enc_br(isa_pkg::OP_JMP, p.size()));
	endfunction

	function automatic void build_random(inout integer seed, output word_q_t p);
		logic [2:0] kind;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [2:0] rs2;
		logic [7:0] addr;
		p = {};
		for (int n = 0; n < 64; n++)
		begin
			kind = 3'($random(seed));
			rd = 3'($random(seed));
			rs1 = 3'($random(seed));
			rs2 = 3'($random(seed));
			// Narrow address window so loads hit earlier stores
			addr = 8'h20 + 8'($random(seed) & 7);
			case (kind)
				3'd0: p.push_back(enc_reg(isa_pkg::OP_ADD, rd, rs2, rs1));
				3'd1: p.push_back(enc_reg(isa_pkg::OP_SUB, rd, rs2, rs1));
				3'd2: p.push_back(enc_reg(isa_pkg::OP_SHL, rd, rs2, rs1));
				3'd3: p.push_back(enc_reg(isa_pkg::OP_ANDB, rd, rs2, rs1));
				3'd4: p.push_back(enc_reg(isa_pkg::OP_ORB, rd, rs2, rs1));
				3'd5: p.push_back(enc_load(rd, addr));
				3'd6: p.push_back(enc_store(addr, rs1));
				default: p.push_back(enc_reg(isa_pkg::OP_NOP, rd, rs2, rs1));
			endcase
		end
		p.push_back(enc_br(isa_pkg::OP_JMP, p.size()));
	endfunction

endpackage

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core;

	logic clk;
	logic reset;
	logic [`PC_W-1:0] pc;
	isa_pkg::instr_u instr;
	logic [`REG_AW-1:0] rf_rd_addr_a;
	logic [`REG_AW-1:0] rf_rd_addr_b;
	logic [`DATA_W-1:0] rf_rd_data_a;
	logic [`DATA_W-1:0] rf_rd_data_b;
	pipe_pkg::rf_write_t rf_wr;
	logic [`ADDR_W-1:0] dmem_rd_addr;
	logic [`DATA_W-1:0] dmem_rd_data;
	pipe_pkg::mem_write_t dmem_wr;

	logic [`INSTR_W-1:0] rom [0:1023];
	logic [`DATA_W-1:0] rf [0:`REG_N-1];
	logic [`DATA_W-1:0] dmem [0:255];
	logic init_mem;
	logic checking;
	string test_name;
	integer seed;
	int limit_cycles;

	// Expected traffic staged by the stimulus for the checker
	tb_model_pkg::rfw_q_t stage_rf;
	tb_model_pkg::memw_q_t stage_mem;
	tb_model_pkg::pc_q_t stage_br;
	tb_model_pkg::rfw_q_t exp_rf;
	tb_model_pkg::memw_q_t exp_mem;
	tb_model_pkg::pc_q_t exp_br;
	logic [`PC_W-1:0] halt_pc;
	logic [`PC_W-1:0] prev_pc;
	logic first_cycle;
	int rst_edges;

	processor_core dut (
		.clk          (clk),
		.reset        (reset),
		.pc           (pc),
		.instr        (instr),
		.rf_rd_addr_a (rf_rd_addr_a),
		.rf_rd_addr_b (rf_rd_addr_b),
		.rf_rd_data_a (rf_rd_data_a),
		.rf_rd_data_b (rf_rd_data_b),
		.rf_wr        (rf_wr),
		.dmem_rd_addr (dmem_rd_addr),
		.dmem_rd_data (dmem_rd_data),
		.dmem_wr      (dmem_wr)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//**********************************************************************
	// Memories around the core
	//**********************************************************************

	assign instr = rom[pc];
	assign rf_rd_data_a = rf[rf_rd_addr_a];
	assign rf_rd_data_b = rf[rf_rd_addr_b];
	assign dmem_rd_data = dmem[dmem_rd_addr];

	always @(posedge clk)
	begin
		if (init_mem)
		begin
			for (int i = 0; i < `REG_N; i++)
				rf[i] <= tb_model_pkg::rf_init(i);
			for (int i = 0; i < 256; i++)
				dmem[i] <= tb_model_pkg::dmem_init(i);
		end
		else
		begin
			if (rf_wr.en)
				rf[rf_wr.addr] <= rf_wr.data;
			if (dmem_wr.en)
				dmem[dmem_wr.addr] <= dmem_wr.data;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp_val, act_val);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("%s in test %s", msg, test_name);
		$display("Regression failed");
		$fatal(1);
	endtask

	//**********************************************************************
	// Checks on the core outputs at the rising edge
	//**********************************************************************

	always @(posedge clk)
	begin
		if (reset)
		begin
			if (rst_edges > 0)
			begin
				assert (!rf_wr.en && !dmem_wr.en)
					else report_failure("write enable high during reset");
				assert (pc == '0)
					else report_mismatch("pc in reset", 32'd0, 32'(pc));
			end
			rst_edges = rst_edges + 1;
			first_cycle = 1'b1;
			exp_rf = stage_rf;
			exp_mem = stage_mem;
			exp_br = stage_br;
		end
		else if (checking)
		begin
			if (first_cycle)
			begin
				assert (pc == '0)
					else report_mismatch("pc after reset", 32'd0, 32'(pc));
				assert (!rf_wr.en && !dmem_wr.en)
					else report_failure("write enable high right after reset");
			end
			else if (pc != prev_pc + 1'b1)
			begin
				// A taken branch must be the next one the model predicts
				if (exp_br.size() > 0 && pc == exp_br[0])
					void'(exp_br.pop_front());
				else
					assert (pc == halt_pc)
						else report_mismatch("branch target",
							32'(exp_br.size() > 0 ? exp_br[0] : halt_pc), 32'(pc));
			end
			if (rf_wr.en)
			begin
				assert (exp_rf.size() > 0)
					else report_failure("register write with none expected");
				assert ({rf_wr.addr, rf_wr.data} == exp_rf[0])
					else report_mismatch("register write", 32'(exp_rf[0]),
						32'({rf_wr.addr, rf_wr.data}));
				void'(exp_rf.pop_front());
			end
			if (dmem_wr.en)
			begin
				assert (exp_mem.size() > 0)
					else report_failure("memory store with none expected");
				assert ({dmem_wr.addr, dmem_wr.data} == exp_mem[0])
					else report_mismatch("memory store", 32'(exp_mem[0]),
						32'({dmem_wr.addr, dmem_wr.data}));
				void'(exp_mem.pop_front());
			end
			prev_pc = pc;
			first_cycle = 1'b0;
		end
	end

	//**********************************************************************
	// Stimulus
	//**********************************************************************

	task automatic run_program(input string name, input tb_model_pkg::word_q_t prog);
		tb_model_pkg::rfw_q_t rq;
		tb_model_pkg::memw_q_t mq;
		tb_model_pkg::pc_q_t bq;
		logic [`PC_W-1:0] h;
		test_name = name;
		checking = 1'b0;
		// The first reset edge of each run still sees the old pc
		rst_edges = 0;
		reset = 1'b1;
		init_mem = 1'b1;
		for (int i = 0; i < 1024; i++)
			rom[i] = (i < prog.size()) ? prog[i] : '0;
		tb_model_pkg::run_model(prog, rq, mq, bq, h);
		stage_rf = rq;
		stage_mem = mq;
		stage_br = bq;
		halt_pc = h;
		repeat (8)
		begin
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
		init_mem = 1'b0;
		checking = 1'b1;
		while (pc != halt_pc)
		begin
			@(posedge clk);
			#1;
		end
		// Older instructions drain within three cycles
		repeat (4)
		begin
			@(posedge clk);
			#1;
		end
		assert (exp_rf.size() == 0 && exp_mem.size() == 0 && exp_br.size() == 0)
			else report_failure("expected writes or branches never happened");
		checking = 1'b0;
	endtask

	initial
	begin
		tb_model_pkg::word_q_t dir_prog;
		tb_model_pkg::word_q_t rnd_prog;
		reset = 1'b1;
		init_mem = 1'b1;
		checking = 1'b0;
		rst_edges = 0;
		first_cycle = 1'b1;
		prev_pc = '0;
		halt_pc = '0;
		limit_cycles = 0;
		test_name = "setup";
		seed = 32'he218_d370;
		tb_model_pkg::build_directed(dir_prog);
		tb_model_pkg::build_random(seed, rnd_prog);
		limit_cycles = (dir_prog.size() + rnd_prog.size()) * 8 + 200;
		run_program("directed", dir_prog);
		run_program("random", rnd_prog);
		$display("Regression passed");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("simulation did not finish in test %s", test_name);
		$display("Regression failed");
		$fatal(1);
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/instr_decoder.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/commit_control.sv
hdl/processor_core.sv
verif/tb_model_pkg.sv
verif/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_core -o tb_core
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/tb_core
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with a failure"
	exit $status
fi
exit 0
